// ==== common/mm_pkg.sv ====
// Matrix-vector accelerator shared types
`default_nettype none

package mm_pkg;

    // Element format and default sizes
    localparam int LANE_W     = 16;
    localparam int FRAC_W_DEF = 8;     // Q8.8
    localparam int DIM_DEF    = 4;     // Lanes per word, rows per block
    localparam int VECS_DEF   = 2;     // Input vectors per job
    localparam int CNT_W_DEF  = 3;

    // One signed Q8.8 element
    typedef logic signed [LANE_W-1:0] lane_t;

    // Lane 0 sits in the lowest bits
    typedef lane_t [DIM_DEF-1:0] word_t;

    // Output FIFO payload
    typedef struct packed {
        word_t data;
        logic  last;                   // Final beat of a job
    } out_beat_t;

    // Controller states
    typedef enum logic [2:0] {
        IDLE    = 3'd0,
        LOAD_W  = 3'd1,
        LOAD_X  = 3'd2,
        COMPUTE = 3'd3
    } mm_state_e;

endpackage

`default_nettype wire

// ==== design/stream_fifo.sv ====
// Valid/ready stream FIFO
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 4
) (
    input  wire logic     aclk,
    input  wire logic     aresetn,
    input  wire logic     in_valid_i,
    output logic          in_ready_o,
    input  wire payload_t in_data_i,
    output logic          out_valid_o,
    input  wire logic     out_ready_i,
    output payload_t      out_data_o
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_en;
    logic             rd_en;

    assign in_ready_o  = (count != CNT_W'(DEPTH)); // Low only when full
    assign out_valid_o = (count != '0);
    assign out_data_o  = mem[rd_ptr];
    assign wr_en       = in_valid_i && in_ready_o;
    assign rd_en       = out_valid_o && out_ready_i;

    always_ff @(posedge aclk)
    begin
        if (wr_en)
        begin
            mem[wr_ptr] <= in_data_i;
        end
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (wr_en)
            begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1; // Wrap at depth
            end
            if (rd_en)
            begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (wr_en && !rd_en)
            begin
                count <= count + 1'b1;
            end
            else if (rd_en && !wr_en)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== mm_core/word_counter.sv ====
// Phase word counter
`timescale 1ns/1ps
`default_nettype none

module word_counter #(
    parameter int WIDTH = 3
) (
    input  wire logic             aclk,
    input  wire logic             aresetn,
    input  wire logic             clear_i,
    input  wire logic             step_i,
    input  wire logic [WIDTH-1:0] limit_i,
    output logic      [WIDTH-1:0] count_o,
    output logic                  at_limit_o
);

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            count_o <= '0;
        end
        else if (clear_i)
        begin
            count_o <= '0;             // Clear wins over step
        end
        else if (step_i)
        begin
            count_o <= count_o + 1'b1;
        end
    end

    assign at_limit_o = (count_o == limit_i);

endmodule

`default_nettype wire

// ==== mm_core/mm_ctrl_fsm.sv ====
// Job sequencing state machine
`timescale 1ns/1ps
`default_nettype none

module mm_ctrl_fsm #(
    parameter int DIM      = mm_pkg::DIM_DEF,
    parameter int NUM_VECS = mm_pkg::VECS_DEF
) (
    input  wire logic                         aclk,
    input  wire logic                         aresetn,
    input  wire logic                         w_valid_i,
    input  wire logic                         x_valid_i,
    input  wire logic                         out_ready_i,
    output logic                              pop_w_o,
    output logic                              pop_x_o,
    output logic                              push_o,
    output logic                              last_o,
    output logic [mm_pkg::CNT_W_DEF-1:0]      count_o
);

    localparam int CNT_W = mm_pkg::CNT_W_DEF;
    localparam logic [CNT_W-1:0] ROW_LIMIT = CNT_W'(DIM - 1);
    localparam logic [CNT_W-1:0] VEC_LIMIT = CNT_W'(NUM_VECS - 1);

    mm_pkg::mm_state_e state_q;
    mm_pkg::mm_state_e state_d;
    logic [CNT_W-1:0]  limit;
    logic              at_limit;
    logic              step;
    logic              phase_done;

    // Weight phase counts rows, the others count vectors
    assign limit = (state_q == mm_pkg::LOAD_W) ? ROW_LIMIT : VEC_LIMIT;

    assign pop_w_o    = (state_q == mm_pkg::LOAD_W) && w_valid_i;
    assign pop_x_o    = (state_q == mm_pkg::LOAD_X) && x_valid_i;
    assign push_o     = (state_q == mm_pkg::COMPUTE);
    assign step       = pop_w_o || pop_x_o || (push_o && out_ready_i); // One word moved
    assign phase_done = step && at_limit;
    assign last_o     = push_o && at_limit;

    word_counter #(
        .WIDTH(CNT_W)
    ) word_counter_i (
        .aclk      (aclk),
        .aresetn   (aresetn),
        .clear_i   (phase_done),
        .step_i    (step),
        .limit_i   (limit),
        .count_o   (count_o),
        .at_limit_o(at_limit)
    );

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            mm_pkg::IDLE:
            begin
                if (w_valid_i)
                begin
                    state_d = mm_pkg::LOAD_W;
                end
            end
            mm_pkg::LOAD_W:
            begin
                if (phase_done)
                begin
                    state_d = mm_pkg::LOAD_X;
                end
            end
            mm_pkg::LOAD_X:
            begin
                if (phase_done)
                begin
                    state_d = mm_pkg::COMPUTE;
                end
            end
            mm_pkg::COMPUTE:
            begin
                if (phase_done)
                begin
                    state_d = mm_pkg::IDLE; // Last beat accepted by output FIFO
                end
            end
            default:
            begin
                state_d = mm_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            state_q <= mm_pkg::IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// ==== mm_core/block_mac.sv ====
// Weight and vector buffers with Q8.8 dot products
`timescale 1ns/1ps
`default_nettype none

module block_mac #(
    parameter int DIM        = mm_pkg::DIM_DEF,
    parameter int NUM_VECS   = mm_pkg::VECS_DEF,
    parameter int FRAC_WIDTH = mm_pkg::FRAC_W_DEF
) (
    input  wire logic                         aclk,
    input  wire logic                         aresetn,
    input  wire mm_pkg::word_t                w_word_i,
    input  wire logic                         w_we_i,
    input  wire mm_pkg::word_t                x_word_i,
    input  wire logic                         x_we_i,
    input  wire logic [mm_pkg::CNT_W_DEF-1:0] sel_i,
    output mm_pkg::word_t                     result_o
);

    localparam int ROW_IDX_W = (DIM > 1) ? $clog2(DIM) : 1;
    localparam int VEC_IDX_W = (NUM_VECS > 1) ? $clog2(NUM_VECS) : 1;

    mm_pkg::word_t        w_rows [DIM];
    mm_pkg::word_t        x_vecs [NUM_VECS];
    logic [ROW_IDX_W-1:0] row_idx;
    logic [VEC_IDX_W-1:0] vec_idx;

    assign row_idx = sel_i[ROW_IDX_W-1:0];
    assign vec_idx = sel_i[VEC_IDX_W-1:0];

    always_ff @(posedge aclk)
    begin
        if (!aresetn)
        begin
            for (int i = 0; i < DIM; i++)
            begin
                w_rows[i] <= '0;
            end
            for (int i = 0; i < NUM_VECS; i++)
            begin
                x_vecs[i] <= '0;
            end
        end
        else
        begin
            if (w_we_i)
            begin
                w_rows[row_idx] <= w_word_i; // One row per word
            end
            if (x_we_i)
            begin
                x_vecs[vec_idx] <= x_word_i;
            end
        end
    end

    // Lane r of the result is row r dotted with the selected vector
    always_comb
    begin
        logic signed [31:0] acc;
        logic signed [31:0] shifted;
        result_o = '0;
        for (int r = 0; r < DIM; r++)
        begin
            acc = '0;
            for (int k = 0; k < DIM; k++)
            begin
                acc = acc + $signed(w_rows[r][k]) * $signed(x_vecs[vec_idx][k]); // 32-bit sum
            end
            shifted     = acc >>> FRAC_WIDTH;  // Back to Q8.8
            result_o[r] = shifted[mm_pkg::LANE_W-1:0]; // Wraps on overflow
        end
    end

endmodule

`default_nettype wire

// ==== design/mm_stream_top.sv ====
// Matrix-vector stream accelerator top
`timescale 1ns/1ps
`default_nettype none

module mm_stream_top #(
    parameter int FRAC_WIDTH = mm_pkg::FRAC_W_DEF,
    parameter int DIM        = mm_pkg::DIM_DEF,
    parameter int NUM_VECS   = mm_pkg::VECS_DEF,
    parameter int FIFO_DEPTH = 4
) (
    input  wire logic          aclk,
    input  wire logic          aresetn,
    // Weight slave stream
    input  wire logic          s_w_valid_i,
    output logic               s_w_ready_o,
    input  wire mm_pkg::word_t s_w_data_i,
    // Input vector slave stream
    input  wire logic          s_x_valid_i,
    output logic               s_x_ready_o,
    input  wire mm_pkg::word_t s_x_data_i,
    // Result master stream
    output logic               m_valid_o,
    input  wire logic          m_ready_i,
    output mm_pkg::word_t      m_data_o,
    output logic               m_last_o
);

    mm_pkg::word_t                w_head;
    mm_pkg::word_t                x_head;
    mm_pkg::word_t                result;
    mm_pkg::out_beat_t            out_beat;
    mm_pkg::out_beat_t            m_beat;
    logic                         w_valid;
    logic                         x_valid;
    logic                         pop_w;
    logic                         pop_x;
    logic                         push;
    logic                         push_ready;
    logic                         last;
    logic [mm_pkg::CNT_W_DEF-1:0] count;

    stream_fifo #(
        .payload_t(mm_pkg::word_t),
        .DEPTH    (FIFO_DEPTH)
    ) w_fifo_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_valid_i (s_w_valid_i),
        .in_ready_o (s_w_ready_o),
        .in_data_i  (s_w_data_i),
        .out_valid_o(w_valid),
        .out_ready_i(pop_w),
        .out_data_o (w_head)
    );

    stream_fifo #(
        .payload_t(mm_pkg::word_t),
        .DEPTH    (FIFO_DEPTH)
    ) x_fifo_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_valid_i (s_x_valid_i),
        .in_ready_o (s_x_ready_o),
        .in_data_i  (s_x_data_i),
        .out_valid_o(x_valid),
        .out_ready_i(pop_x),
        .out_data_o (x_head)
    );

    mm_ctrl_fsm #(
        .DIM     (DIM),
        .NUM_VECS(NUM_VECS)
    ) mm_ctrl_fsm_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .w_valid_i  (w_valid),
        .x_valid_i  (x_valid),
        .out_ready_i(push_ready),
        .pop_w_o    (pop_w),
        .pop_x_o    (pop_x),
        .push_o     (push),
        .last_o     (last),
        .count_o    (count)
    );

    block_mac #(
        .DIM       (DIM),
        .NUM_VECS  (NUM_VECS),
        .FRAC_WIDTH(FRAC_WIDTH)
    ) block_mac_i (
        .aclk    (aclk),
        .aresetn (aresetn),
        .w_word_i(w_head),
        .w_we_i  (pop_w),              // Captured on the FIFO pop
        .x_word_i(x_head),
        .x_we_i  (pop_x),
        .sel_i   (count),
        .result_o(result)
    );

    assign out_beat.data = result;
    assign out_beat.last = last;

    stream_fifo #(
        .payload_t(mm_pkg::out_beat_t),
        .DEPTH    (FIFO_DEPTH)
    ) out_fifo_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .in_valid_i (push),
        .in_ready_o (push_ready),
        .in_data_i  (out_beat),
        .out_valid_o(m_valid_o),
        .out_ready_i(m_ready_i),
        .out_data_o (m_beat)
    );

    assign m_data_o = m_beat.data;
    assign m_last_o = m_beat.last;

endmodule

`default_nettype wire

// ==== dv/mm_stream_sva.sv ====
// Stream protocol assertions
`timescale 1ns/1ps
`default_nettype none

module mm_stream_sva (
    input wire logic          aclk,
    input wire logic          aresetn,
    input wire logic          s_w_valid_i,
    input wire logic          s_w_ready_o,
    input wire mm_pkg::word_t s_w_data_i,
    input wire logic          s_x_valid_i,
    input wire logic          s_x_ready_o,
    input wire mm_pkg::word_t s_x_data_i,
    input wire logic          m_valid_o,
    input wire logic          m_ready_i,
    input wire mm_pkg::word_t m_data_o,
    input wire logic          m_last_o
);

    w_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_w_valid_i && !s_w_ready_o |=> s_w_valid_i && $stable(s_w_data_i))
        else $error("Weight beat dropped or changed while stalled");

    x_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        s_x_valid_i && !s_x_ready_o |=> s_x_valid_i && $stable(s_x_data_i))
        else $error("Input vector beat dropped or changed while stalled");

    // Master beat holds data and last until it transfers
    m_hold: assert property (@(posedge aclk) disable iff (!aresetn)
        m_valid_o && !m_ready_i |=> m_valid_o && $stable(m_data_o) && $stable(m_last_o))
        else $error("Result beat dropped or changed while stalled");

    m_reset: assert property (@(posedge aclk) !aresetn |=> !m_valid_o)
        else $error("Result valid high after reset");

endmodule

bind mm_stream_top mm_stream_sva mm_stream_sva_i (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .s_w_valid_i(s_w_valid_i),
    .s_w_ready_o(s_w_ready_o),
    .s_w_data_i (s_w_data_i),
    .s_x_valid_i(s_x_valid_i),
    .s_x_ready_o(s_x_ready_o),
    .s_x_data_i (s_x_data_i),
    .m_valid_o  (m_valid_o),
    .m_ready_i  (m_ready_i),
    .m_data_o   (m_data_o),
    .m_last_o   (m_last_o)
);

`default_nettype wire

// ==== dv/mm_stream_tb.sv ====
// Matrix-vector stream testbench
`timescale 1ns/1ps
`default_nettype none

module mm_stream_tb;

    localparam int          DIM      = mm_pkg::DIM_DEF;
    localparam int          NUM_VECS = mm_pkg::VECS_DEF;
    localparam int          FRAC_W   = mm_pkg::FRAC_W_DEF;
    localparam int          NUM_JOBS = 6;
    localparam int          TIMEOUT  = 200;            // Cycles per wait loop
    localparam logic [31:0] SEED     = 32'hae31_e2c1;

    logic          aclk;
    logic          aresetn;
    logic          s_w_valid_i;
    logic          s_w_ready_o;
    mm_pkg::word_t s_w_data_i;
    logic          s_x_valid_i;
    logic          s_x_ready_o;
    mm_pkg::word_t s_x_data_i;
    logic          m_valid_o;
    logic          m_ready_i;
    mm_pkg::word_t m_data_o;
    logic          m_last_o;

    mm_pkg::word_t w_tab [NUM_JOBS][DIM];         // Weight block per job
    mm_pkg::word_t x_tab [NUM_JOBS][NUM_VECS];
    bit            stall_tab [NUM_JOBS];          // Random gaps and m_ready stalls
    logic [31:0]   gen_lfsr;

    mm_stream_top #(
        .FRAC_WIDTH(FRAC_W),
        .DIM       (DIM),
        .NUM_VECS  (NUM_VECS),
        .FIFO_DEPTH(4)
    ) mm_stream_top_i (
        .aclk       (aclk),
        .aresetn    (aresetn),
        .s_w_valid_i(s_w_valid_i),
        .s_w_ready_o(s_w_ready_o),
        .s_w_data_i (s_w_data_i),
        .s_x_valid_i(s_x_valid_i),
        .s_x_ready_o(s_x_ready_o),
        .s_x_data_i (s_x_data_i),
        .m_valid_o  (m_valid_o),
        .m_ready_i  (m_ready_i),
        .m_data_o   (m_data_o),
        .m_last_o   (m_last_o)
    );

    initial
    begin
        aclk = 1'b0;
        forever
        begin
            #4 aclk = ~aclk;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic mm_pkg::word_t lanes(input logic [15:0] l0, l1, l2, l3);
        mm_pkg::word_t w;
        w[0] = l0;                                     // Lane 0 lowest
        w[1] = l1;
        w[2] = l2;
        w[3] = l3;
        return w;
    endfunction

    // Row r dotted with the vector, shifted back to Q8.8, low 16 bits kept
    function automatic mm_pkg::word_t expected_word(input int job, input int vec);
        mm_pkg::word_t      res;
        logic signed [31:0] sum;
        logic signed [31:0] scaled;
        for (int r = 0; r < DIM; r++)
        begin
            sum = '0;
            for (int k = 0; k < DIM; k++)
            begin
                sum = sum + 32'($signed(w_tab[job][r][k])) * 32'($signed(x_tab[job][vec][k]));
            end
            scaled = sum >>> FRAC_W;
            res[r] = scaled[15:0];
        end
        return res;
    endfunction

    task automatic draw_lane(output mm_pkg::lane_t v);
        for (int b = 0; b < 16; b++)
        begin
            gen_lfsr = lfsr_step(gen_lfsr);
            v[b]     = gen_lfsr[0];
        end
    endtask

    task automatic fill_table();
        mm_pkg::lane_t rl;
        for (int r = 0; r < DIM; r++)
        begin
            w_tab[0][r]    = '0;
            w_tab[0][r][r] = 16'h0100;                 // Identity times 1.0
        end
        x_tab[0][0] = lanes(16'h0180, 16'hfdc0, 16'h0080, 16'h0300);
        x_tab[0][1] = lanes(16'h7fff, 16'h8000, 16'h0001, 16'hffff);
        w_tab[1][0] = lanes(16'h0100, 16'hff00, 16'h0080, 16'hff80);
        w_tab[1][1] = lanes(16'hffc0, 16'h0040, 16'hfe00, 16'h0200);
        w_tab[1][2] = lanes(16'h0001, 16'hffff, 16'h0003, 16'hfffd);
        w_tab[1][3] = lanes(16'h0123, 16'hfedc, 16'h0456, 16'hfba9);
        x_tab[1][0] = lanes(16'h0101, 16'hfe7f, 16'h0033, 16'hff01);
        x_tab[1][1] = lanes(16'hffff, 16'h0001, 16'hfffe, 16'h0002);
        w_tab[2][0] = lanes(16'h4000, 16'h4000, 16'h4000, 16'h4000); // Sums past 16 bits
        w_tab[2][1] = lanes(16'h7fff, 16'h7fff, 16'h7fff, 16'h7fff);
        w_tab[2][2] = lanes(16'h8000, 16'h8000, 16'h7fff, 16'h7fff);
        w_tab[2][3] = lanes(16'h2000, 16'he000, 16'h2000, 16'he000);
        x_tab[2][0] = lanes(16'h0800, 16'h0800, 16'h0800, 16'h0800);
        x_tab[2][1] = lanes(16'h7fff, 16'h8000, 16'h1234, 16'hedcb);
        for (int j = 0; j < NUM_JOBS; j++)
        begin
            stall_tab[j] = (j >= 3);
            for (int i = 0; i < DIM * (DIM + NUM_VECS) && j >= 3; i++)
            begin
                draw_lane(rl);
                if (i < DIM * DIM)
                begin
                    w_tab[j][i / DIM][i % DIM] = rl;
                end
                else
                begin
                    x_tab[j][(i - DIM * DIM) / DIM][i % DIM] = rl;
                end
            end
        end
    endtask

    task automatic wait_cycle();
        @(posedge aclk);
        #1;                                            // Drive and sample off the edge
    endtask

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("Simulation failed");
        $fatal(1, "Run stopped at first failure");
    endtask

    task automatic check_word(input mm_pkg::word_t got, input mm_pkg::word_t exp,
                              input string what);
        if (got !== exp)
        begin
            abort_run($sformatf("ERROR: time %0t: %s data %h, expected %h",
                                $time, what, got, exp));
        end
    endtask

    task automatic check_last(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            abort_run($sformatf("ERROR: time %0t: %s last %0b, expected %0b",
                                $time, what, got, exp));
        end
    endtask

    // Sends one beat on the weight or input stream
    task automatic send_word(input bit to_x, input mm_pkg::word_t d, input bit gaps,
                             inout logic [31:0] st);
        int waited;
        waited = 0;
        if (gaps)
        begin
            st = lfsr_step(st);
            if (st[0])
            begin
                wait_cycle();                          // Idle gap before the beat
            end
        end
        if (to_x)
        begin
            s_x_valid_i = 1'b1;
            s_x_data_i  = d;
        end
        else
        begin
            s_w_valid_i = 1'b1;
            s_w_data_i  = d;
        end
        while (!(to_x ? s_x_ready_o : s_w_ready_o))
        begin
            waited++;
            if (waited > TIMEOUT)
            begin
                abort_run(to_x ? "Input stream ready never came back"
                               : "Weight stream ready never came back");
            end
            wait_cycle();
        end
        wait_cycle();
        if (to_x)
        begin
            s_x_valid_i = 1'b0;
        end
        else
        begin
            s_w_valid_i = 1'b0;
        end
    endtask

    task automatic receive_beat(input bit stalls, inout logic [31:0] st,
                                output mm_pkg::word_t data, output logic last);
        int   waited;
        logic got;
        waited = 0;
        got    = 1'b0;
        while (!got)
        begin
            if (stalls)
            begin
                st        = lfsr_step(st);
                m_ready_i = st[0];
            end
            else
            begin
                m_ready_i = 1'b1;
            end
            got  = m_valid_o && m_ready_i;
            data = m_data_o;
            last = m_last_o;
            wait_cycle();
            waited++;
            if (!got && waited > TIMEOUT)
            begin
                abort_run("No result beat arrived in time");
            end
        end
    endtask

    initial
    begin
        logic [31:0]   w_st;
        logic [31:0]   x_st;
        logic [31:0]   m_st;
        mm_pkg::word_t got_word;
        logic          got_last;
        aresetn     = 1'b0;
        s_w_valid_i = 1'b0;
        s_w_data_i  = '0;
        s_x_valid_i = 1'b0;
        s_x_data_i  = '0;
        m_ready_i   = 1'b0;
        gen_lfsr    = SEED;
        fill_table();
        w_st = gen_lfsr;
        x_st = lfsr_step(gen_lfsr);
        m_st = lfsr_step(x_st);
        repeat (10) @(posedge aclk);
        #1 aresetn = 1'b1;
        fork
            for (int j = 0; j < NUM_JOBS; j++)
            begin
                for (int r = 0; r < DIM; r++)
                begin
                    send_word(1'b0, w_tab[j][r], stall_tab[j], w_st);
                end
            end
            for (int j = 0; j < NUM_JOBS; j++)
            begin
                for (int v = 0; v < NUM_VECS; v++)
                begin
                    send_word(1'b1, x_tab[j][v], stall_tab[j], x_st);
                end
            end
            for (int j = 0; j < NUM_JOBS; j++)
            begin
                for (int v = 0; v < NUM_VECS; v++)
                begin
                    receive_beat(stall_tab[j], m_st, got_word, got_last);
                    check_word(got_word, expected_word(j, v),
                               $sformatf("job %0d vector %0d", j, v));
                    check_last(got_last, (v == NUM_VECS - 1),
                               $sformatf("job %0d vector %0d", j, v));
                end
            end
        join
        m_ready_i = 1'b1;
        for (int i = 0; i < 20; i++)
        begin
            if (m_valid_o)
            begin
                abort_run("Unexpected extra result beat after the last job");
            end
            wait_cycle();
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== mm_stream.f ====
common/mm_pkg.sv
design/stream_fifo.sv
mm_core/word_counter.sv
mm_core/mm_ctrl_fsm.sv
mm_core/block_mac.sv
design/mm_stream_top.sv
dv/mm_stream_sva.sv
dv/mm_stream_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module mm_stream_tb \
    -f mm_stream.f

./obj_dir/Vmm_stream_tb
